//--- Makefile
# Verilator build and run for the SHA-512 core testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_sha512_core
FILELIST  ?= sha512_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
FAIL_MSG  ?= Something failed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/sha512_compress.sv
// SHA-512 compression datapath
// Working variables a..h, the round function and the chaining digest H0..H7
`timescale 1ns/1ps

module sha512_compress
  import sha512_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   zeroize,
  input  logic                   state_init,
  input  logic                   first_block,
  input  logic                   round_step,
  input  logic                   digest_update,
  input  logic [ROUND_CTR_W-1:0] round_idx,
  input  word_t                  w_val,
  output logic [DIGEST_W-1:0]    digest
);

  // Working variables
  word_t a_reg;
  word_t b_reg;
  word_t c_reg;
  word_t d_reg;
  word_t e_reg;
  word_t f_reg;
  word_t g_reg;
  word_t h_reg;

  // Chaining digest H0..H7
  word_t dig_reg [0:7];

  // Round terms
  word_t t1;
  word_t t2;
  word_t init_val [0:7];

  // ----------------------------------------
  // Round function
  // ----------------------------------------
  always_comb
  begin
    t1 = h_reg + big_sigma1(e_reg) + ch(e_reg, f_reg, g_reg) + K_TABLE[round_idx] + w_val;
    t2 = big_sigma0(a_reg) + maj(a_reg, b_reg, c_reg);
  end

  // New message starts from the IV and later blocks chain from the digest
  always_comb
  begin
    for (int i = 0; i < 8; i++)
      init_val[i] = first_block ? H_INIT[i] : dig_reg[i];
  end

  assign digest = {dig_reg[0], dig_reg[1], dig_reg[2], dig_reg[3],
                   dig_reg[4], dig_reg[5], dig_reg[6], dig_reg[7]};

  // ----------------------------------------
  // State and digest registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      a_reg <= '0;
      b_reg <= '0;
      c_reg <= '0;
      d_reg <= '0;
      e_reg <= '0;
      f_reg <= '0;
      g_reg <= '0;
      h_reg <= '0;
      for (int i = 0; i < 8; i++)
        dig_reg[i] <= '0;
    end
    else if (zeroize)
    begin
      a_reg <= '0;
      b_reg <= '0;
      c_reg <= '0;
      d_reg <= '0;
      e_reg <= '0;
      f_reg <= '0;
      g_reg <= '0;
      h_reg <= '0;
      for (int i = 0; i < 8; i++)
        dig_reg[i] <= '0;
    end
    else
    begin
      if (state_init)
      begin
        a_reg <= init_val[0];
        b_reg <= init_val[1];
        c_reg <= init_val[2];
        d_reg <= init_val[3];
        e_reg <= init_val[4];
        f_reg <= init_val[5];
        g_reg <= init_val[6];
        h_reg <= init_val[7];
        // First block also seeds the digest with the IV
        if (first_block)
          for (int i = 0; i < 8; i++)
            dig_reg[i] <= H_INIT[i];
      end
      else if (round_step)
      begin
        // Shift down the chain while a and e take the new sums
        a_reg <= t1 + t2;
        b_reg <= a_reg;
        c_reg <= b_reg;
        d_reg <= c_reg;
        e_reg <= d_reg + t1;
        f_reg <= e_reg;
        g_reg <= f_reg;
        h_reg <= g_reg;
      end
      else if (digest_update)
      begin
        // Feed-forward add modulo 2^64
        dig_reg[0] <= dig_reg[0] + a_reg;
        dig_reg[1] <= dig_reg[1] + b_reg;
        dig_reg[2] <= dig_reg[2] + c_reg;
        dig_reg[3] <= dig_reg[3] + d_reg;
        dig_reg[4] <= dig_reg[4] + e_reg;
        dig_reg[5] <= dig_reg[5] + f_reg;
        dig_reg[6] <= dig_reg[6] + g_reg;
        dig_reg[7] <= dig_reg[7] + h_reg;
      end
    end
  end

endmodule

//--- hdl/sha512_core.sv
// SHA-512 compression core
// Controller, message schedule and round datapath for one block at a time
`timescale 1ns/1ps

module sha512_core
  import sha512_pkg::*;
(
  input  logic                clk,
  input  logic                reset_n,
  input  logic                zeroize,
  input  logic                init_cmd,
  input  logic                next_cmd,
  input  logic [BLOCK_W-1:0]  block_msg,
  output logic                ready,
  output logic [DIGEST_W-1:0] digest,
  output logic                digest_valid
);

  // Controller strobes
  logic                   load_block;
  logic                   state_init;
  logic                   first_block;
  logic                   round_step;
  logic                   digest_update;
  logic [ROUND_CTR_W-1:0] round_idx;

  // Schedule word into the round
  word_t                  w_val;

  // ----------------------------------------
  // Block sequencing
  // ----------------------------------------
  sha512_ctrl i_sha512_ctrl (
    .clk           (clk),
    .reset_n       (reset_n),
    .zeroize       (zeroize),
    .init_cmd      (init_cmd),
    .next_cmd      (next_cmd),
    .load_block    (load_block),
    .state_init    (state_init),
    .first_block   (first_block),
    .round_step    (round_step),
    .digest_update (digest_update),
    .round_idx     (round_idx),
    .ready         (ready),
    .digest_valid  (digest_valid)
  );

  // Message schedule
  sha512_w_mem i_sha512_w_mem (
    .clk        (clk),
    .reset_n    (reset_n),
    .zeroize    (zeroize),
    .block_msg  (block_msg),
    .load_block (load_block),
    .round_step (round_step),
    .w_val      (w_val)
  );

  // Round datapath and digest
  sha512_compress i_sha512_compress (
    .clk           (clk),
    .reset_n       (reset_n),
    .zeroize       (zeroize),
    .state_init    (state_init),
    .first_block   (first_block),
    .round_step    (round_step),
    .digest_update (digest_update),
    .round_idx     (round_idx),
    .w_val         (w_val),
    .digest        (digest)
  );

endmodule

//--- hdl/sha512_ctrl.sv
// SHA-512 block controller
// Accepts a command, steps the 80 rounds, then folds the result into the digest
`timescale 1ns/1ps

module sha512_ctrl
  import sha512_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   zeroize,
  input  logic                   init_cmd,
  input  logic                   next_cmd,
  output logic                   load_block,
  output logic                   state_init,
  output logic                   first_block,
  output logic                   round_step,
  output logic                   digest_update,
  output logic [ROUND_CTR_W-1:0] round_idx,
  output logic                   ready,
  output logic                   digest_valid
);

  ctrl_state_t            state_reg;
  ctrl_state_t            state_next;
  logic [ROUND_CTR_W-1:0] round_ctr;
  logic                   accept;
  logic                   last_round;

  // Commands only count while idle, init wins over next
  assign accept     = (state_reg == CTRL_IDLE) && (init_cmd || next_cmd);
  assign last_round = (round_ctr == ROUND_CTR_W'(NUM_ROUNDS - 1));

  // ----------------------------------------
  // Datapath strobes
  // ----------------------------------------
  // Load happens on the accepting edge itself
  assign load_block    = accept;
  assign state_init    = accept;
  assign first_block   = accept && init_cmd;
  assign round_step    = (state_reg == CTRL_ROUNDS);
  assign digest_update = (state_reg == CTRL_DONE);
  assign round_idx     = round_ctr;

  // Next state
  always_comb
  begin
    state_next = state_reg;
    unique case (state_reg)
      CTRL_IDLE:
        if (accept)
          state_next = CTRL_ROUNDS;
      CTRL_ROUNDS:
        // Leave after round 79
        if (last_round)
          state_next = CTRL_DONE;
      CTRL_DONE:
        state_next = CTRL_IDLE;
      default:
        state_next = CTRL_IDLE;
    endcase
  end

  // ----------------------------------------
  // Control registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_reg    <= CTRL_IDLE;
      round_ctr    <= '0;
      ready        <= 1'b1;
      digest_valid <= 1'b0;
    end
    else if (zeroize)
    begin
      state_reg    <= CTRL_IDLE;
      round_ctr    <= '0;
      ready        <= 1'b1;
      digest_valid <= 1'b0;
    end
    else
    begin
      state_reg <= state_next;
      // Counter parks on the last round so the K lookup stays in range
      if (accept)
        round_ctr <= '0;
      else if (round_step && !last_round)
        round_ctr <= round_ctr + 1'b1;
      if (accept)
      begin
        ready        <= 1'b0;
        digest_valid <= 1'b0;
      end
      else if (digest_update)
      begin
        ready        <= 1'b1;
        digest_valid <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/sha512_pkg.sv
// SHA-512 shared definitions
// Word type, controller states, round constants, initial hash and round functions
package sha512_pkg;

  // One SHA-512 word
  typedef logic [63:0] word_t;

  // Controller states
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_ROUNDS,
    CTRL_DONE
  } ctrl_state_t;

  // Fixed sizes from the standard
  localparam int NUM_ROUNDS  = 80;
  localparam int ROUND_CTR_W = 7;
  localparam int BLOCK_W     = 1024;
  localparam int DIGEST_W    = 512;

  // ----------------------------------------
  // Round constants K0..K79
  // ----------------------------------------
  localparam word_t K_TABLE [0:NUM_ROUNDS-1] = '{
    64'h428a2f98d728ae22, 64'h7137449123ef65cd,
    64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
    64'h3956c25bf348b538, 64'h59f111f1b605d019,
    64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
    64'hd807aa98a3030242, 64'h12835b0145706fbe,
    64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
    64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1,
    64'h9bdc06a725c71235, 64'hc19bf174cf692694,
    64'he49b69c19ef14ad2, 64'hefbe4786384f25e3,
    64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
    64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483,
    64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
    64'h983e5152ee66dfab, 64'ha831c66d2db43210,
    64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
    64'hc6e00bf33da88fc2, 64'hd5a79147930aa725,
    64'h06ca6351e003826f, 64'h142929670a0e6e70,
    64'h27b70a8546d22ffc, 64'h2e1b21385c26c926,
    64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
    64'h650a73548baf63de, 64'h766a0abb3c77b2a8,
    64'h81c2c92e47edaee6, 64'h92722c851482353b,
    64'ha2bfe8a14cf10364, 64'ha81a664bbc423001,
    64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
    64'hd192e819d6ef5218, 64'hd69906245565a910,
    64'hf40e35855771202a, 64'h106aa07032bbd1b8,
    64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53,
    64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
    64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb,
    64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
    64'h748f82ee5defb2fc, 64'h78a5636f43172f60,
    64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
    64'h90befffa23631e28, 64'ha4506cebde82bde9,
    64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
    64'hca273eceea26619c, 64'hd186b8c721c0c207,
    64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
    64'h06f067aa72176fba, 64'h0a637dc5a2c898a6,
    64'h113f9804bef90dae, 64'h1b710b35131c471b,
    64'h28db77f523047d84, 64'h32caab7b40c72493,
    64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
    64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a,
    64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
  };

  // SHA-512 initial hash H0..H7
  localparam word_t H_INIT [0:7] = '{
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b,
    64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f,
    64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  // ----------------------------------------
  // Round functions
  // ----------------------------------------

  // Rotate right by n bits
  function automatic word_t rotr(input word_t x, input int n);
    return (x >> n) | (x << (64 - n));
  endfunction

  // Sigma0 on the a path
  function automatic word_t big_sigma0(input word_t x);
    return rotr(x, 28) ^ rotr(x, 34) ^ rotr(x, 39);
  endfunction

  // Sigma1 on the e path
  function automatic word_t big_sigma1(input word_t x);
    return rotr(x, 14) ^ rotr(x, 18) ^ rotr(x, 41);
  endfunction

  // Schedule sigma0, last term is a plain shift
  function automatic word_t small_sigma0(input word_t x);
    return rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
  endfunction

  // Schedule sigma1
  function automatic word_t small_sigma1(input word_t x);
    return rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
  endfunction

  // e selects between f and g
  function automatic word_t ch(input word_t x, input word_t y, input word_t z);
    return (x & y) ^ (~x & z);
  endfunction

  // Bitwise majority vote
  function automatic word_t maj(input word_t x, input word_t y, input word_t z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

endpackage

//--- hdl/sha512_w_mem.sv
// SHA-512 message schedule
// Sixteen-word sliding window, one new schedule word per round
`timescale 1ns/1ps

module sha512_w_mem
  import sha512_pkg::*;
(
  input  logic               clk,
  input  logic               reset_n,
  input  logic               zeroize,
  input  logic [BLOCK_W-1:0] block_msg,
  input  logic               load_block,
  input  logic               round_step,
  output word_t              w_val
);

  // Window holds W[t] .. W[t+15], head at index 0
  word_t w_reg [0:15];
  word_t w_new;

  // ----------------------------------------
  // Recurrence for W[t+16]
  // ----------------------------------------
  // W[t+16] = s1(W[t+14]) + W[t+9] + s0(W[t+1]) + W[t]
  always_comb
  begin
    w_new = small_sigma1(w_reg[14]) + w_reg[9] + small_sigma0(w_reg[1]) + w_reg[0];
  end

  // Current round word
  assign w_val = w_reg[0];

  // ----------------------------------------
  // Window registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < 16; i++)
        w_reg[i] <= '0;
    end
    else if (zeroize)
    begin
      for (int i = 0; i < 16; i++)
        w_reg[i] <= '0;
    end
    else if (load_block)
    begin
      // Most significant word of the block is W0
      for (int i = 0; i < 16; i++)
        w_reg[i] <= block_msg[BLOCK_W-1-64*i -: 64];
    end
    else if (round_step)
    begin
      // Slide toward the head
      for (int i = 0; i < 15; i++)
        w_reg[i] <= w_reg[i+1];
      w_reg[15] <= w_new;
    end
  end

endmodule

//--- sha512_core.f
hdl/sha512_pkg.sv
hdl/sha512_ctrl.sv
hdl/sha512_w_mem.sv
hdl/sha512_compress.sv
hdl/sha512_core.sv
testbench/sha512_core_assert.sv
testbench/tb_sha512_core.sv

//--- testbench/sha512_core_assert.sv
// SHA-512 controller assertions
// Checks the ready and digest_valid sequence around each accepted command
`timescale 1ns/1ps

module sha512_ctrl_assert (
  input logic clk,
  input logic reset_n,
  input logic zeroize,
  input logic init_cmd,
  input logic next_cmd,
  input logic ready,
  input logic digest_valid
);

  // Cycles since acceptance, 1 right after the accepting edge
  logic [7:0] busy_cnt;
  logic       accept_cmd;

  // Ready is high exactly when the controller is idle
  assign accept_cmd = ready && (init_cmd || next_cmd);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      busy_cnt <= '0;
    else if (zeroize)
      busy_cnt <= '0;
    else if (accept_cmd)
      busy_cnt <= 8'd1;
    else if (!ready)
      busy_cnt <= busy_cnt + 8'd1;
  end

  // ----------------------------------------
  // No finished digest while busy
  a_valid_needs_ready : assert property (@(posedge clk) disable iff (!reset_n)
    digest_valid |-> ready)
    else $error("digest_valid is high while ready is low");

  // Accepted command takes the core busy
  a_accept_drops_ready : assert property (@(posedge clk) disable iff (!reset_n)
    (accept_cmd && !zeroize) |=> !ready)
    else $error("ready did not drop after an accepted command");

  // Busy for the rounds, no early return
  a_busy_holds : assert property (@(posedge clk) disable iff (!reset_n)
    (!ready && !zeroize && busy_cnt < 8'd81) |=> !ready)
    else $error("ready returned before 81 cycles");

  // Ready back on the 81st edge
  a_ready_returns : assert property (@(posedge clk) disable iff (!reset_n)
    (!ready && !zeroize && busy_cnt == 8'd81) |=> ready)
    else $error("ready did not return 81 cycles after acceptance");

endmodule

bind sha512_ctrl sha512_ctrl_assert i_sha512_ctrl_assert (
  .clk          (clk),
  .reset_n      (reset_n),
  .zeroize      (zeroize),
  .init_cmd     (init_cmd),
  .next_cmd     (next_cmd),
  .ready        (ready),
  .digest_valid (digest_valid)
);

//--- testbench/tb_sha512_core.sv
// SHA-512 core testbench
// Known answer, random, chained, busy and zeroize blocks against a reference model
`timescale 1ns/1ps

module tb_sha512_core
  import sha512_pkg::*;
;

  localparam int SEED        = 21268;
  localparam int NUM_RANDOM  = 4;
  // abc, randoms, three chained, busy, zeroized plus follow-up
  localparam int NUM_BLOCKS  = 1 + NUM_RANDOM + 3 + 1 + 2;
  localparam int CYCLE_LIMIT = NUM_BLOCKS * 100 + 200;

  // Padded "abc" and its published digest
  localparam logic [BLOCK_W-1:0] ABC_BLOCK = {24'h616263, 8'h80, 864'h0, 128'd24};
  localparam logic [DIGEST_W-1:0] ABC_DIGEST = {
    64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2,
    64'h0a9eeee64b55d39a, 64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd,
    64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f};
  localparam logic [DIGEST_W-1:0] IV_DIGEST = {H_INIT[0], H_INIT[1], H_INIT[2],
    H_INIT[3], H_INIT[4], H_INIT[5], H_INIT[6], H_INIT[7]};

  logic                clk;
  logic                reset_n;
  logic                zeroize;
  logic                init_cmd;
  logic                next_cmd;
  logic [BLOCK_W-1:0]  block_msg;
  logic                ready;
  logic [DIGEST_W-1:0] digest;
  logic                digest_valid;

  // Handoff between stimulus and checker
  logic                check_pending;
  logic [DIGEST_W-1:0] exp_digest;

  int    error_count;
  int    check_count;
  int    tests_run;
  int    tests_failed;
  int    test_errors_at_start;
  int    cycle_count;
  string test_name;

  sha512_core i_sha512_core (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (zeroize),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .block_msg    (block_msg),
    .ready        (ready),
    .digest       (digest),
    .digest_valid (digest_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------
  // Reference model, one compression
  // ----------------------------------------
  function automatic logic [DIGEST_W-1:0] sha512_ref_block(
    input logic [DIGEST_W-1:0] h_in,
    input logic [BLOCK_W-1:0]  blk
  );
    word_t w [0:NUM_ROUNDS-1];
    word_t v [0:7];
    word_t h [0:7];
    word_t t1;
    word_t t2;
    for (int t = 0; t < 8; t++)
    begin
      h[t] = h_in[DIGEST_W-1-64*t -: 64];
      v[t] = h[t];
    end
    // Schedule, W0 is the top word of the block
    for (int t = 0; t < 16; t++)
      w[t] = blk[BLOCK_W-1-64*t -: 64];
    for (int t = 16; t < NUM_ROUNDS; t++)
      w[t] = small_sigma1(w[t-2]) + w[t-7] + small_sigma0(w[t-15]) + w[t-16];
    for (int t = 0; t < NUM_ROUNDS; t++)
    begin
      t1 = v[7] + big_sigma1(v[4]) + ch(v[4], v[5], v[6]) + K_TABLE[t] + w[t];
      t2 = big_sigma0(v[0]) + maj(v[0], v[1], v[2]);
      for (int i = 7; i > 0; i--)
        v[i] = v[i-1];
      v[4] = v[4] + t1;
      v[0] = t1 + t2;
    end
    // Feed-forward into the chaining value
    for (int t = 0; t < 8; t++)
      h[t] = h[t] + v[t];
    return {h[0], h[1], h[2], h[3], h[4], h[5], h[6], h[7]};
  endfunction

  function automatic logic [BLOCK_W-1:0] random_block();
    logic [BLOCK_W-1:0] blk;
    for (int i = 0; i < BLOCK_W / 32; i++)
      blk[32*i +: 32] = $urandom();
    return blk;
  endfunction

  task automatic check_value(input string name, input logic [DIGEST_W-1:0] actual,
                             input logic [DIGEST_W-1:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("[ERROR] time %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic open_test(input string name);
    test_name            = name;
    test_errors_at_start = error_count;
  endtask

  task automatic close_test();
    int errs;
    errs = error_count - test_errors_at_start;
    tests_run++;
    if (errs != 0)
      tests_failed++;
    $display("Test %-10s %s (%0d errors)", test_name, (errs == 0) ? "passed" : "FAILED", errs);
  endtask

  // Present a command, return right after the accepting edge
  task automatic start_block(input logic is_init, input logic [BLOCK_W-1:0] blk);
    @(posedge clk);
    block_msg <= blk;
    init_cmd  <= is_init;
    next_cmd  <= !is_init;
    @(posedge clk);
    init_cmd  <= 1'b0;
    next_cmd  <= 1'b0;
  endtask

  task automatic run_block(input logic is_init, input logic [BLOCK_W-1:0] blk,
                           input logic [DIGEST_W-1:0] expected);
    start_block(is_init, blk);
    exp_digest    = expected;
    check_pending = 1'b1;
    wait (!check_pending);
  endtask

  // ----------------------------------------
  // Checker, counts edges from acceptance
  // ----------------------------------------
  initial
  begin
    check_pending = 1'b0;
    forever
    begin
      wait (check_pending);
      for (int i = 1; i <= 81; i++)
      begin
        @(posedge clk);
        @(negedge clk);
        // Still busy one edge before the result
        if (i == 80)
        begin
          check_value("ready", DIGEST_W'(ready), DIGEST_W'(1'b0));
          check_value("digest_valid", DIGEST_W'(digest_valid), DIGEST_W'(1'b0));
        end
      end
      check_value("digest", digest, exp_digest);
      check_value("ready", DIGEST_W'(ready), DIGEST_W'(1'b1));
      check_value("digest_valid", DIGEST_W'(digest_valid), DIGEST_W'(1'b1));
      check_pending = 1'b0;
    end
  end

  // Watchdog
  initial
  begin
    cycle_count = 0;
    forever
    begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT)
      begin
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial
  begin
    logic [BLOCK_W-1:0]  blk;
    logic [DIGEST_W-1:0] chain;
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_n      = 1'b0;
    zeroize      = 1'b0;
    init_cmd     = 1'b0;
    next_cmd     = 1'b0;
    block_msg    = '0;
    void'($urandom(SEED));
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;

    open_test("abc");
    check_value("ref_abc", sha512_ref_block(IV_DIGEST, ABC_BLOCK), ABC_DIGEST);
    run_block(1'b1, ABC_BLOCK, ABC_DIGEST);
    close_test();

    open_test("random");
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      blk = random_block();
      run_block(1'b1, blk, sha512_ref_block(IV_DIGEST, blk));
    end
    close_test();

    // Three blocks of one message
    open_test("chaining");
    chain = IV_DIGEST;
    for (int n = 0; n < 3; n++)
    begin
      blk   = random_block();
      chain = sha512_ref_block(chain, blk);
      run_block(n == 0, blk, chain);
    end
    close_test();

    // Commands during the rounds must be ignored
    open_test("busy");
    blk = random_block();
    start_block(1'b1, blk);
    exp_digest    = sha512_ref_block(IV_DIGEST, blk);
    check_pending = 1'b1;
    repeat (20) @(posedge clk);
    block_msg <= random_block();
    init_cmd  <= 1'b1;
    @(posedge clk);
    init_cmd  <= 1'b0;
    next_cmd  <= 1'b1;
    @(posedge clk);
    next_cmd  <= 1'b0;
    wait (!check_pending);
    close_test();

    // Abort a block halfway, then hash again
    open_test("zeroize");
    start_block(1'b1, random_block());
    repeat (30) @(posedge clk);
    zeroize <= 1'b1;
    @(posedge clk);
    zeroize <= 1'b0;
    @(negedge clk);
    check_value("digest", digest, '0);
    check_value("ready", DIGEST_W'(ready), DIGEST_W'(1'b1));
    check_value("digest_valid", DIGEST_W'(digest_valid), DIGEST_W'(1'b0));
    blk = random_block();
    run_block(1'b1, blk, sha512_ref_block(IV_DIGEST, blk));
    close_test();

    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
